// File: rtl/uart_pkg.sv
// ==============================
// UART peripheral shared definitions
// Widths, APB register map, control and status bit positions
// and the serial state machine encodings
// ==============================
package uart_pkg;

    localparam int UART_DATA_W     = 8;
    localparam int CLK_DIV_W       = 16;
    localparam int APB_ADDR_W      = 8;
    localparam int APB_DATA_W      = 32;
    localparam int CTRL_W          = 4;
    localparam int STAT_W          = 3;
    localparam int UART_FIFO_DEPTH = 16;

    typedef logic [UART_DATA_W-1:0] uart_data_t;
    typedef logic [CLK_DIV_W-1:0]   clk_div_t;
    typedef logic [APB_ADDR_W-1:0]  apb_addr_t;
    typedef logic [APB_DATA_W-1:0]  apb_data_t;

    // Register map, byte addresses
    localparam apb_addr_t CLK_DIVIDER_ADDR = 8'h00;
    localparam apb_addr_t CONTROL_ADDR     = 8'h04;
    localparam apb_addr_t STATUS_ADDR      = 8'h08;
    localparam apb_addr_t TX_DATA_ADDR     = 8'h0C;
    localparam apb_addr_t RX_DATA_ADDR     = 8'h10;

    localparam int CTRL_TX_EN       = 0;
    localparam int CTRL_RX_EN       = 1;
    localparam int CTRL_PARITY_EVEN = 2;
    localparam int CTRL_PARITY_ODD  = 3;

    localparam int STAT_RX_EMPTY   = 0;
    localparam int STAT_TX_FULL    = 1;
    localparam int STAT_PARITY_ERR = 2;

    typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} uart_tx_state_t;
    typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_PARITY, RX_STOP} uart_rx_state_t;

endpackage

// File: rtl/uart_fifo.sv
// ==============================
// Synchronous byte FIFO with valid/ready
// handshakes on both sides
// ==============================
`timescale 1ns/1ps

module uart_fifo #(
    parameter int FIFO_DEPTH = uart_pkg::UART_FIFO_DEPTH
) (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                s_valid_i,
    input  uart_pkg::uart_data_t s_data_i,
    output logic                s_ready_o,
    output logic                m_valid_o,
    output uart_pkg::uart_data_t m_data_o,
    input  logic                m_ready_i
);
    import uart_pkg::*;

    localparam int ADDR_W = $clog2(FIFO_DEPTH);

    uart_data_t mem [FIFO_DEPTH];

    // Pointers carry one extra wrap bit to tell full from empty
    logic [ADDR_W:0] wr_ptr_q;
    logic [ADDR_W:0] rd_ptr_q;
    logic            full;
    logic            empty;
    logic            push;
    logic            pop;

    assign empty = (wr_ptr_q == rd_ptr_q);
    assign full  = (wr_ptr_q[ADDR_W] != rd_ptr_q[ADDR_W]) &&
                   (wr_ptr_q[ADDR_W-1:0] == rd_ptr_q[ADDR_W-1:0]);

    assign s_ready_o = ~full;
    assign m_valid_o = ~empty;
    assign m_data_o  = mem[rd_ptr_q[ADDR_W-1:0]];

    assign push = s_valid_i & s_ready_o;
    assign pop  = m_valid_o & m_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            mem[wr_ptr_q[ADDR_W-1:0]] <= s_data_i;
        end
    end

endmodule

// File: rtl/uart_tx.sv
// ==============================
// UART serializer, 8 data bits LSB first
// with optional parity and one stop bit
// ==============================
`timescale 1ns/1ps

module uart_tx (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  uart_pkg::clk_div_t   clk_div_i,
    input  logic                 parity_even_i,
    input  logic                 parity_odd_i,
    input  logic                 s_valid_i,
    input  uart_pkg::uart_data_t s_data_i,
    output logic                 s_ready_o,
    output logic                 uart_tx_o
);
    import uart_pkg::*;

    uart_tx_state_t                   state_q;
    clk_div_t                         cnt_q;
    logic [$clog2(UART_DATA_W)-1:0]   bit_idx_q;
    uart_data_t                       shift_q;
    logic                             par_bit_q;
    logic                             par_en_q;
    logic                             tx_q;
    logic                             bit_end;

    assign s_ready_o = (state_q == TX_IDLE);
    assign uart_tx_o = tx_q;
    assign bit_end   = (cnt_q == clk_div_i);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q   <= TX_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            par_en_q  <= 1'b0;
            tx_q      <= 1'b1;
        end else begin
            if (state_q == TX_IDLE || bit_end) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end

            case (state_q)
                TX_IDLE: begin
                    if (s_valid_i) begin
                        par_en_q <= parity_even_i | parity_odd_i;
                        tx_q     <= 1'b0;
                        state_q  <= TX_START;
                    end
                end
                TX_START: begin
                    if (bit_end) begin
                        tx_q    <= shift_q[0];
                        state_q <= TX_DATA;
                    end
                end
                TX_DATA: begin
                    if (bit_end) begin
                        if (bit_idx_q == UART_DATA_W - 1) begin
                            bit_idx_q <= '0;
                            tx_q      <= par_en_q ? par_bit_q : 1'b1;
                            state_q   <= par_en_q ? TX_PARITY : TX_STOP;
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                            tx_q      <= shift_q[0];
                        end
                    end
                end
                TX_PARITY: begin
                    if (bit_end) begin
                        tx_q    <= 1'b1;
                        state_q <= TX_STOP;
                    end
                end
                TX_STOP: begin
                    if (bit_end) begin
                        state_q <= TX_IDLE;
                    end
                end
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    // Even parity takes priority when both modes are set
    always_ff @(posedge clk_i) begin
        if (s_ready_o && s_valid_i) begin
            shift_q   <= s_data_i;
            par_bit_q <= parity_even_i ? ^s_data_i : ~^s_data_i;
        end else if (bit_end && (state_q == TX_START || state_q == TX_DATA)) begin
            shift_q <= shift_q >> 1;
        end
    end

endmodule

// File: rtl/uart_rx.sv
// ==============================
// UART deserializer with mid-bit sampling,
// parity check and sticky parity error
// ==============================
`timescale 1ns/1ps

module uart_rx (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  uart_pkg::clk_div_t   clk_div_i,
    input  logic                 parity_even_i,
    input  logic                 parity_odd_i,
    input  logic                 uart_rx_i,
    output logic                 m_valid_o,
    output uart_pkg::uart_data_t m_data_o,
    input  logic                 m_ready_i,
    output logic                 parity_err_o
);
    import uart_pkg::*;

    uart_rx_state_t                   state_q;
    clk_div_t                         cnt_q;
    logic [$clog2(UART_DATA_W)-1:0]   bit_idx_q;
    logic [1:0]                       sync_q;
    logic                             rx_prev_q;
    uart_data_t                       shift_q;
    logic                             par_q;
    logic                             par_en_q;
    logic                             par_odd_q;
    logic                             valid_q;
    logic                             err_q;
    logic                             rx_s;
    logic                             fall;
    logic                             bit_mid;
    logic                             par_bad;

    assign rx_s = sync_q[1];
    assign fall = rx_prev_q & ~rx_s;

    // The start bit is confirmed at half period, every later bit one full period on
    assign bit_mid = (state_q == RX_START) ? (cnt_q == (clk_div_i >> 1)) :
                                             (cnt_q == clk_div_i);

    assign par_bad = par_en_q & ((^{shift_q, par_q}) != par_odd_q);

    // The byte is offered for a single cycle and is lost if the FIFO is full
    assign m_valid_o    = valid_q;
    assign m_data_o     = shift_q;
    assign parity_err_o = err_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            sync_q    <= 2'b11;
            rx_prev_q <= 1'b1;
            state_q   <= RX_IDLE;
            cnt_q     <= '0;
            bit_idx_q <= '0;
            par_en_q  <= 1'b0;
            par_odd_q <= 1'b0;
            valid_q   <= 1'b0;
            err_q     <= 1'b0;
        end else begin
            sync_q    <= {sync_q[0], uart_rx_i};
            rx_prev_q <= rx_s;
            valid_q   <= 1'b0;

            if (state_q == RX_IDLE || bit_mid) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end

            case (state_q)
                RX_IDLE: begin
                    if (fall) begin
                        par_en_q  <= parity_even_i | parity_odd_i;
                        par_odd_q <= ~parity_even_i & parity_odd_i;
                        state_q   <= RX_START;
                    end
                end
                RX_START: begin
                    // A glitch shorter than half a bit falls back to idle
                    if (bit_mid) begin
                        state_q <= rx_s ? RX_IDLE : RX_DATA;
                    end
                end
                RX_DATA: begin
                    if (bit_mid) begin
                        if (bit_idx_q == UART_DATA_W - 1) begin
                            bit_idx_q <= '0;
                            state_q   <= par_en_q ? RX_PARITY : RX_STOP;
                        end else begin
                            bit_idx_q <= bit_idx_q + 1'b1;
                        end
                    end
                end
                RX_PARITY: begin
                    if (bit_mid) begin
                        state_q <= RX_STOP;
                    end
                end
                RX_STOP: begin
                    if (bit_mid) begin
                        state_q <= RX_IDLE;
                        if (par_bad) begin
                            err_q <= 1'b1;
                        end else begin
                            valid_q <= 1'b1;
                        end
                    end
                end
                default: state_q <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == RX_DATA && bit_mid) begin
            shift_q <= {rx_s, shift_q[UART_DATA_W-1:1]};
        end
        if (state_q == RX_PARITY && bit_mid) begin
            par_q <= rx_s;
        end
    end

endmodule

// File: rtl/apb_uart.sv
// ==============================
// APB UART top level
// Register decode, TX holding register, FIFOs
// and serial engines
// ==============================
`timescale 1ns/1ps

module apb_uart #(
    parameter int FIFO_DEPTH = uart_pkg::UART_FIFO_DEPTH
) (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  uart_pkg::apb_addr_t paddr_i,
    input  uart_pkg::apb_data_t pwdata_i,
    output uart_pkg::apb_data_t prdata_o,
    output logic                pready_o,
    output logic                pslverr_o,
    input  logic                uart_rx_i,
    output logic                uart_tx_o
);
    import uart_pkg::*;

    logic              access;
    logic              wr_en;
    logic              rd_en;
    logic              addr_mapped;
    logic              addr_ro;
    apb_data_t         rd_data;
    clk_div_t          clk_div_q;
    logic [CTRL_W-1:0] ctrl_q;
    logic [STAT_W-1:0] status;
    logic              tx_rstn;
    logic              rx_rstn;
    uart_data_t        tx_hold_data_q;
    logic              tx_hold_valid_q;
    logic              tx_fifo_s_valid;
    logic              tx_fifo_s_ready;
    logic              tx_fifo_m_valid;
    logic              tx_fifo_m_ready;
    uart_data_t        tx_fifo_m_data;
    logic              rx_fifo_s_valid;
    logic              rx_fifo_s_ready;
    uart_data_t        rx_fifo_s_data;
    logic              rx_fifo_m_valid;
    uart_data_t        rx_fifo_m_data;
    logic              rx_pop;
    logic              parity_err;

    assign access = psel_i & penable_i;
    assign wr_en  = access & pwrite_i;
    assign rd_en  = access & ~pwrite_i;

    assign tx_rstn = rstn_i & ctrl_q[CTRL_TX_EN];
    assign rx_rstn = rstn_i & ctrl_q[CTRL_RX_EN];

    assign status[STAT_RX_EMPTY]   = ~rx_fifo_m_valid;
    assign status[STAT_TX_FULL]    = tx_hold_valid_q;
    assign status[STAT_PARITY_ERR] = parity_err;

    always_comb begin
        rd_data     = '0;
        addr_mapped = 1'b1;
        addr_ro     = 1'b0;
        case (paddr_i)
            CLK_DIVIDER_ADDR: rd_data = apb_data_t'(clk_div_q);
            CONTROL_ADDR:     rd_data = apb_data_t'(ctrl_q);
            TX_DATA_ADDR:     rd_data = apb_data_t'(tx_hold_data_q);
            STATUS_ADDR: begin
                rd_data = apb_data_t'(status);
                addr_ro = 1'b1;
            end
            RX_DATA_ADDR: begin
                rd_data = apb_data_t'(rx_fifo_m_data);
                addr_ro = 1'b1;
            end
            default: addr_mapped = 1'b0;
        endcase
    end

    assign prdata_o  = rd_en ? rd_data : '0;
    assign pready_o  = 1'b1;
    assign pslverr_o = access & (~addr_mapped | (pwrite_i & addr_ro));

    assign rx_pop = rd_en & (paddr_i == RX_DATA_ADDR);

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            clk_div_q <= '0;
            ctrl_q    <= '0;
        end else if (wr_en) begin
            if (paddr_i == CLK_DIVIDER_ADDR) begin
                clk_div_q <= pwdata_i[CLK_DIV_W-1:0];
            end
            if (paddr_i == CONTROL_ADDR) begin
                ctrl_q <= pwdata_i[CTRL_W-1:0];
            end
        end
    end

    // The holding register keeps its byte while tx is disabled, so one byte
    // can be queued before the path is switched on
    assign tx_fifo_s_valid = tx_hold_valid_q & ctrl_q[CTRL_TX_EN];

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            tx_hold_data_q  <= '0;
            tx_hold_valid_q <= 1'b0;
        end else if (wr_en && paddr_i == TX_DATA_ADDR) begin
            tx_hold_data_q  <= pwdata_i[UART_DATA_W-1:0];
            tx_hold_valid_q <= 1'b1;
        end else if (tx_fifo_s_valid && tx_fifo_s_ready) begin
            tx_hold_valid_q <= 1'b0;
        end
    end

    uart_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_fifo_tx (
        .clk_i    (clk_i),
        .rstn_i   (tx_rstn),
        .s_valid_i(tx_fifo_s_valid),
        .s_data_i (tx_hold_data_q),
        .s_ready_o(tx_fifo_s_ready),
        .m_valid_o(tx_fifo_m_valid),
        .m_data_o (tx_fifo_m_data),
        .m_ready_i(tx_fifo_m_ready)
    );

    uart_tx i_uart_tx (
        .clk_i        (clk_i),
        .rstn_i       (tx_rstn),
        .clk_div_i    (clk_div_q),
        .parity_even_i(ctrl_q[CTRL_PARITY_EVEN]),
        .parity_odd_i (ctrl_q[CTRL_PARITY_ODD]),
        .s_valid_i    (tx_fifo_m_valid),
        .s_data_i     (tx_fifo_m_data),
        .s_ready_o    (tx_fifo_m_ready),
        .uart_tx_o    (uart_tx_o)
    );

    uart_rx i_uart_rx (
        .clk_i        (clk_i),
        .rstn_i       (rx_rstn),
        .clk_div_i    (clk_div_q),
        .parity_even_i(ctrl_q[CTRL_PARITY_EVEN]),
        .parity_odd_i (ctrl_q[CTRL_PARITY_ODD]),
        .uart_rx_i    (uart_rx_i),
        .m_valid_o    (rx_fifo_s_valid),
        .m_data_o     (rx_fifo_s_data),
        .m_ready_i    (rx_fifo_s_ready),
        .parity_err_o (parity_err)
    );

    uart_fifo #(
        .FIFO_DEPTH(FIFO_DEPTH)
    ) i_fifo_rx (
        .clk_i    (clk_i),
        .rstn_i   (rx_rstn),
        .s_valid_i(rx_fifo_s_valid),
        .s_data_i (rx_fifo_s_data),
        .s_ready_o(rx_fifo_s_ready),
        .m_valid_o(rx_fifo_m_valid),
        .m_data_o (rx_fifo_m_data),
        .m_ready_i(rx_pop)
    );

endmodule

// File: sim/tb_apb_uart.sv
// ==============================
// APB UART testbench
// APB and serial driver tasks, LFSR, value check
// and the directed test sequence
// ==============================
`timescale 1ns/1ps

module tb_apb_uart;
    import uart_pkg::*;

    localparam apb_addr_t REG_DIV    = 8'h00;
    localparam apb_addr_t REG_CTRL   = 8'h04;
    localparam apb_addr_t REG_STATUS = 8'h08;
    localparam apb_addr_t REG_TX     = 8'h0C;
    localparam apb_addr_t REG_RX     = 8'h10;

    localparam apb_data_t CTL_TX   = 32'h1;
    localparam apb_data_t CTL_RX   = 32'h2;
    localparam apb_data_t CTL_EVEN = 32'h4;
    localparam apb_data_t CTL_ODD  = 32'h8;

    localparam int RX_EMPTY_BIT = 0;
    localparam int TX_FULL_BIT  = 1;
    localparam int PAR_ERR_BIT  = 2;

    logic        clk_i;
    logic        rstn_i;
    logic        psel_i;
    logic        penable_i;
    logic        pwrite_i;
    apb_addr_t   paddr_i;
    apb_data_t   pwdata_i;
    apb_data_t   prdata_o;
    logic        pready_o;
    logic        pslverr_o;
    logic        uart_rx_i;
    logic        uart_tx_o;
    logic        loopback;
    logic        ser_line;
    logic [15:0] lfsr_q;
    int          bit_cycles;
    uart_data_t  exp_q[$];

    apb_uart i_dut (
        .clk_i    (clk_i),
        .rstn_i   (rstn_i),
        .psel_i   (psel_i),
        .penable_i(penable_i),
        .pwrite_i (pwrite_i),
        .paddr_i  (paddr_i),
        .pwdata_i (pwdata_i),
        .prdata_o (prdata_o),
        .pready_o (pready_o),
        .pslverr_o(pslverr_o),
        .uart_rx_i(uart_rx_i),
        .uart_tx_o(uart_tx_o)
    );

    // The receiver listens either to the transmitter or to the serial driver
    assign uart_rx_i = loopback ? uart_tx_o : ser_line;

    initial begin
        clk_i = 1'b0;
        forever #10 clk_i = ~clk_i;
    end

    task automatic stop_on_failure();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string name, input apb_data_t got, input apb_data_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
            stop_on_failure();
        end
    endtask

    task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
        @(negedge clk_i);
        psel_i    = 1'b1;
        pwrite_i  = 1'b1;
        paddr_i   = addr;
        pwdata_i  = data;
        penable_i = 1'b0;
        @(negedge clk_i);
        penable_i = 1'b1;
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(negedge clk_i);
        psel_i    = 1'b1;
        pwrite_i  = 1'b0;
        paddr_i   = addr;
        penable_i = 1'b0;
        @(negedge clk_i);
        penable_i = 1'b1;
        // Read data and the error flag are combinational during the access phase
        #5;
        data = prdata_o;
        err  = pslverr_o;
        check_value("pready_o", {31'h0, pready_o}, 32'h1);
        @(negedge clk_i);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic wait_status(input int bit_pos, input logic value, input int max_polls,
                               output logic seen);
        apb_data_t stat;
        logic      err;
        seen = 1'b0;
        for (int i = 0; i < max_polls && !seen; i++) begin
            apb_read(REG_STATUS, stat, err);
            seen = (stat[bit_pos] == value);
        end
    endtask

    task automatic expect_status(input int bit_pos, input logic value, input string what);
        logic seen;
        wait_status(bit_pos, value, 500, seen);
        if (!seen) begin
            $display("Timeout while waiting for %s", what);
            stop_on_failure();
        end
    endtask

    task automatic wait_tx_low(input int max_cycles);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < max_cycles && !seen; i++) begin
            @(negedge clk_i);
            seen = (uart_tx_o == 1'b0);
        end
        if (!seen) begin
            $display("Timeout while waiting for a start bit on uart_tx_o");
            stop_on_failure();
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_byte(output uart_data_t b);
        b = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            b      = {b[6:0], lfsr_q[0]};
        end
    endtask

    task automatic send_frame(input uart_data_t data, input logic par_en, input logic par_odd,
                              input logic flip_parity);
        logic [10:0] bits;
        logic        par;
        int          n;
        par  = (^data) ^ par_odd ^ flip_parity;
        bits = par_en ? {1'b1, par, data, 1'b0} : {2'b11, data, 1'b0};
        n    = par_en ? 11 : 10;
        @(negedge clk_i);
        for (int i = 0; i < n; i++) begin
            ser_line = bits[i];
            repeat (bit_cycles) @(negedge clk_i);
        end
    endtask

    task automatic loopback_bytes(input int count);
        uart_data_t b;
        apb_data_t  rd;
        logic       err;
        for (int i = 0; i < count; i++) begin
            random_byte(b);
            expect_status(TX_FULL_BIT, 1'b0, "the TX holding register to drain");
            apb_write(REG_TX, {24'h0, b});
            expect_status(RX_EMPTY_BIT, 1'b0, "a received byte");
            apb_read(REG_RX, rd, err);
            check_value("RX_DATA", rd, {24'h0, b});
        end
    endtask

    // Reset state and an unmapped access
    task automatic reset_defaults();
        apb_data_t rd;
        logic      err;
        apb_read(REG_STATUS, rd, err);
        check_value("STATUS", rd, 32'h1);
        check_value("pslverr_o", {31'h0, err}, 32'h0);
        check_value("uart_tx_o", {31'h0, uart_tx_o}, 32'h1);
        apb_read(8'h20, rd, err);
        check_value("pslverr_o", {31'h0, err}, 32'h1);
    endtask

    // Loopback without parity, then with even and odd parity
    task automatic parity_mode_loopback();
        apb_data_t rd;
        logic      err;
        apb_write(REG_DIV, 32'd3);
        bit_cycles = 4;
        apb_write(REG_CTRL, CTL_TX | CTL_RX);
        loopback_bytes(8);
        apb_write(REG_CTRL, CTL_TX | CTL_RX | CTL_EVEN);
        loopback_bytes(4);
        apb_write(REG_CTRL, CTL_TX | CTL_RX | CTL_ODD);
        loopback_bytes(4);
        apb_read(REG_STATUS, rd, err);
        check_value("STATUS", rd, 32'h1);
    endtask

    // Bad parity from the serial driver, then a good frame
    task automatic bad_parity_frame();
        apb_data_t  rd;
        logic       err;
        uart_data_t b;
        loopback = 1'b0;
        apb_write(REG_CTRL, CTL_TX | CTL_RX | CTL_EVEN);
        random_byte(b);
        send_frame(b, 1'b1, 1'b0, 1'b1);
        expect_status(PAR_ERR_BIT, 1'b1, "the parity error flag");
        apb_read(REG_STATUS, rd, err);
        check_value("STATUS", rd, 32'h5);
        apb_write(REG_CTRL, CTL_TX | CTL_EVEN);
        apb_write(REG_CTRL, CTL_TX | CTL_RX | CTL_EVEN);
        apb_read(REG_STATUS, rd, err);
        check_value("STATUS", rd, 32'h1);
        send_frame(b, 1'b1, 1'b0, 1'b0);
        expect_status(RX_EMPTY_BIT, 1'b0, "the frame from the serial driver");
        apb_read(REG_RX, rd, err);
        check_value("RX_DATA", rd, {24'h0, b});
    endtask

    // The first frame of the burst is lost because rx is still off
    task automatic late_rx_burst();
        apb_data_t  rd;
        logic       err;
        logic       seen;
        uart_data_t b;
        int         got;
        loopback = 1'b1;
        apb_write(REG_CTRL, CTL_TX);
        apb_write(REG_DIV, 32'd7);
        bit_cycles = 8;
        exp_q.delete();
        random_byte(b);
        apb_write(REG_TX, {24'h0, b});
        wait_tx_low(20);
        fork
            begin
                for (int i = 0; i < 3; i++) begin
                    random_byte(b);
                    exp_q.push_back(b);
                    apb_write(REG_TX, {24'h0, b});
                end
            end
            // Rx comes on in the middle of the first stop bit
            repeat (9 * bit_cycles + bit_cycles / 2 - 3) @(negedge clk_i);
        join
        apb_write(REG_CTRL, CTL_TX | CTL_RX);
        got  = 0;
        seen = 1'b1;
        while (seen) begin
            wait_status(RX_EMPTY_BIT, 1'b0, 200, seen);
            if (seen) begin
                apb_read(REG_RX, rd, err);
                if (exp_q.size() == 0) begin
                    $display("RX_DATA returned 0x%0h after all burst bytes were read", rd);
                    stop_on_failure();
                end else begin
                    check_value("RX_DATA", rd, {24'h0, exp_q.pop_front()});
                    got++;
                end
            end
        end
        if (got < 1) begin
            $display("No byte of the burst reached RX_DATA");
            stop_on_failure();
        end
    endtask

    // A byte waits in the holding register while tx is off
    task automatic held_tx_byte();
        apb_data_t  rd;
        logic       err;
        uart_data_t b;
        apb_write(REG_DIV, 32'd3);
        bit_cycles = 4;
        apb_write(REG_CTRL, CTL_RX);
        random_byte(b);
        apb_write(REG_TX, {24'h0, b});
        for (int i = 0; i < 100; i++) begin
            @(negedge clk_i);
            check_value("uart_tx_o", {31'h0, uart_tx_o}, 32'h1);
        end
        apb_read(REG_STATUS, rd, err);
        check_value("STATUS", rd, 32'h3);
        apb_write(REG_CTRL, CTL_TX | CTL_RX);
        expect_status(RX_EMPTY_BIT, 1'b0, "the byte held while tx was off");
        apb_read(REG_RX, rd, err);
        check_value("RX_DATA", rd, {24'h0, b});
    endtask

    initial begin
        rstn_i     = 1'b0;
        psel_i     = 1'b0;
        penable_i  = 1'b0;
        pwrite_i   = 1'b0;
        paddr_i    = '0;
        pwdata_i   = '0;
        loopback   = 1'b1;
        ser_line   = 1'b1;
        lfsr_q     = 16'd55;
        bit_cycles = 1;
        repeat (2) @(negedge clk_i);
        rstn_i = 1'b1;

        reset_defaults();
        parity_mode_loopback();
        bad_parity_frame();
        late_rx_burst();
        held_tx_byte();

        $display("TEST OK");
        $finish;
    end

endmodule

// File: list.f
rtl/uart_pkg.sv
rtl/uart_fifo.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/apb_uart.sv
sim/tb_apb_uart.sv

// File: Makefile
TOP = tb_apb_uart

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal -f list.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TEST OK" sim.log

clean:
	rm -rf obj_dir sim.log
